/* design/kd_leaf_encoder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree leaf encoder
// Turns the final path into the reported leaf index and miss flag
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kd_leaf_encoder #(
  parameter int DEPTH = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,      // From the last tree level
  input  logic [DEPTH-1:0]  in_path,       // Full route, root decision in the MSB
  input  logic              in_miss,
  output logic              result_valid,  // One strobe per query
  output logic [DEPTH-1:0]  leaf_index,
  output logic              leaf_miss
);

  // Result strobe
  // One cycle behind the last level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= in_valid;
    end
  end

  // Result payload
  // Loaded only with a valid path so the host sees a stable
  // value between strobes
  always_ff @(posedge clk) begin
    if (in_valid) begin
      leaf_index <= in_path;   // Path bits already form the leaf number
      leaf_miss  <= in_miss;   // Set if any node on the route was unprogrammed
    end
  end

endmodule

/* design/kd_node_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree node loader
// Walks the node address in breadth-first order and turns each host write
// into a one-hot strobe for the addressed node
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kd_node_loader
  import kd_pkg::*;
#(
  parameter int DEPTH = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_start,   // Rewind to the root
  input  logic                   cfg_wen,     // Write and advance
  input  node_word_t             cfg_data,
  output logic [(2**DEPTH)-2:0]  node_wen,    // One strobe per node, root at bit 0
  output node_word_t             node_word,
  output logic                   cfg_loaded   // Whole tree written since last rewind
);

  localparam int NUM_NODES = (2**DEPTH) - 1;
  localparam logic [DEPTH-1:0] LAST_ADDR = DEPTH'(NUM_NODES - 1);

  logic [DEPTH-1:0] wadr;     // Breadth-first node address
  logic             wr_fire;  // Write actually lands this cycle
  logic             wr_last;  // Address points at the final node

  // A rewind in the same cycle as a write wins and drops that write
  assign wr_fire = cfg_wen && !cfg_start;
  assign wr_last = (wadr == LAST_ADDR);

  // Address counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wadr <= '0;
    end else if (cfg_start) begin
      wadr <= '0;
    end else if (cfg_wen) begin
      wadr <= wr_last ? '0 : wadr + 1'b1;  // Wrap back to root after last node
    end
  end

  // Loaded flag set by the write to the last node
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_loaded <= 1'b0;
    end else if (cfg_start) begin
      cfg_loaded <= 1'b0;
    end else if (wr_fire && wr_last) begin
      cfg_loaded <= 1'b1;
    end
  end

  // One-hot decode of the address
  always_comb begin
    node_wen = '0;
    if (wr_fire) begin
      node_wen[wadr] = 1'b1;
    end
  end

  assign node_word = cfg_data;  // Same word goes to every node, strobe picks one

endmodule

/* design/kd_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree shared types
// Patch geometry, node word layout and the reset marker of an unprogrammed node
// ~~~~~~~~~~~~~~~~~~~~
package kd_pkg;

  // Patch geometry
  localparam int NUM_DIMS = 5;                   // Coordinates per patch
  localparam int COORD_W  = 11;                  // Bits per signed coordinate
  localparam int PATCH_W  = NUM_DIMS * COORD_W;  // 55 bit patch

  // Node word layout
  // Dimension index sits in the low bits, median in the upper coordinate slot
  localparam int DIM_W   = 3;
  localparam int NODE_W  = 2 * COORD_W;  // 22 bit node word
  localparam int MED_LSB = COORD_W;      // Median occupies bits 21:11

  // One coordinate of a patch, or a node median
  typedef logic signed [COORD_W-1:0] coord_t;

  // Dimension index, 0 to 4 valid
  typedef logic [DIM_W-1:0] dim_t;

  // Five coordinates, dimension 0 in the lowest field
  typedef logic [PATCH_W-1:0] patch_t;

  // Host node word, bits 10:3 unused
  typedef logic [NODE_W-1:0] node_word_t;

  // Marker held by a node that was never written
  localparam dim_t DIM_UNSET = 3'd7;

endpackage

/* design/kd_tree_level.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree search level
// Holds the 2^LEVEL nodes of one tree level, steers the travelling patch
// left or right and registers it for the next level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kd_tree_level
  import kd_pkg::*;
#(
  parameter int DEPTH = 6,
  parameter int LEVEL = 0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [(2**LEVEL)-1:0]   node_wen,   // Slot s is the node with path value s
  input  node_word_t              node_word,
  input  logic                    in_valid,
  input  patch_t                  in_patch,
  input  logic [DEPTH-1:0]        in_path,    // Decisions taken so far, newest in bit 0
  input  logic                    in_miss,
  output logic                    out_valid,
  output patch_t                  out_patch,
  output logic [DEPTH-1:0]        out_path,
  output logic                    out_miss
);

  localparam int NUM_SLOTS = 2**LEVEL;
  // Root level has a single node, select width kept at one bit
  localparam int SEL_W = (LEVEL > 0) ? LEVEL : 1;

  dim_t   node_dim [NUM_SLOTS];  // Split dimension per node
  coord_t node_med [NUM_SLOTS];  // Split median per node

  logic [SEL_W-1:0] sel;        // Node the patch currently sits at
  dim_t             cur_dim;
  coord_t           cur_med;
  coord_t           cur_coord;  // Patch coordinate picked by cur_dim
  logic             node_miss;  // Node holds no valid dimension
  logic             go_right;
  logic [DEPTH-1:0] next_path;

  // Node storage
  always_ff @(posedge clk) begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (!rst_n) begin
        node_dim[s] <= DIM_UNSET;  // Flags any route through an unwritten node
        node_med[s] <= '0;
      end else if (node_wen[s]) begin
        node_dim[s] <= node_word[DIM_W-1:0];
        node_med[s] <= node_word[MED_LSB +: COORD_W];
      end
    end
  end

  // Low LEVEL bits of the path name the node within this level
  assign sel     = (LEVEL > 0) ? in_path[SEL_W-1:0] : '0;
  assign cur_dim = node_dim[sel];
  assign cur_med = node_med[sel];

  // Coordinate slice, zero for an out of range dimension
  always_comb begin
    cur_coord = '0;
    node_miss = 1'b1;
    for (int d = 0; d < NUM_DIMS; d++) begin
      if (cur_dim == dim_t'(d)) begin
        cur_coord = in_patch[d*COORD_W +: COORD_W];
        node_miss = 1'b0;
      end
    end
  end

  // Strictly less goes left, ties go right
  assign go_right = !(cur_coord < cur_med);  // Both operands signed

  // Shift in the new decision
  assign next_path = DEPTH'({in_path, go_right});

  // Valid bit of the pipeline stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Stage payload, qualified downstream by out_valid
  always_ff @(posedge clk) begin
    out_patch <= in_patch;
    out_path  <= next_path;
    out_miss  <= in_miss | node_miss;  // Sticky along the route
  end

endmodule

/* design/kd_tree_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree search unit
// Node loader, DEPTH pipelined tree levels and the leaf encoder
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kd_tree_top
  import kd_pkg::*;
#(
  parameter int DEPTH = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cfg_start,
  input  logic              cfg_wen,
  input  node_word_t        cfg_data,
  input  logic              query_valid,
  input  patch_t            query_patch,
  output logic              result_valid,
  output logic [DEPTH-1:0]  leaf_index,
  output logic              leaf_miss,
  output logic              cfg_loaded
);

  localparam int NUM_NODES = (2**DEPTH) - 1;

  logic [NUM_NODES-1:0] node_wen;  // Breadth-first write strobes
  node_word_t           node_word;

  // Stage k feeds level k, stage DEPTH feeds the encoder
  patch_t           lvl_patch [DEPTH+1];
  logic [DEPTH-1:0] lvl_path  [DEPTH+1];
  logic [DEPTH:0]   lvl_valid;
  logic [DEPTH:0]   lvl_miss;

  kd_node_loader #(.DEPTH(DEPTH)) u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_start  (cfg_start),
    .cfg_wen    (cfg_wen),
    .cfg_data   (cfg_data),
    .node_wen   (node_wen),
    .node_word  (node_word),
    .cfg_loaded (cfg_loaded)
  );

  // Queries enter at the root with an empty path and no miss
  assign lvl_patch[0] = query_patch;
  assign lvl_path[0]  = '0;
  assign lvl_valid[0] = query_valid;
  assign lvl_miss[0]  = 1'b0;

  for (genvar l = 0; l < DEPTH; l++) begin : g_level
    kd_tree_level #(.DEPTH(DEPTH), .LEVEL(l)) u_level (
      .clk       (clk),
      .rst_n     (rst_n),
      .node_wen  (node_wen[(2**l)-1 +: 2**l]),  // Nodes of level l
      .node_word (node_word),
      .in_valid  (lvl_valid[l]),
      .in_patch  (lvl_patch[l]),
      .in_path   (lvl_path[l]),
      .in_miss   (lvl_miss[l]),
      .out_valid (lvl_valid[l+1]),
      .out_patch (lvl_patch[l+1]),
      .out_path  (lvl_path[l+1]),
      .out_miss  (lvl_miss[l+1])
    );
  end

  kd_leaf_encoder #(.DEPTH(DEPTH)) u_encoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (lvl_valid[DEPTH]),
    .in_path      (lvl_path[DEPTH]),
    .in_miss      (lvl_miss[DEPTH]),
    .result_valid (result_valid),
    .leaf_index   (leaf_index),
    .leaf_miss    (leaf_miss)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the KD-tree testbench with Verilator.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=kd_tree_sim

verilator --binary --timing --assert -j 0 \
  --top-module kd_tree_tb \
  --Mdir obj_dir -o "$BIN" \
  -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, exit status $run_status"
  exit 1
fi

/* tb/kd_tree_props.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree search properties
// Result latency, reset state and result sanity on the top level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kd_tree_props #(
  parameter int DEPTH = 6
) (
  input logic             clk,
  input logic             rst_n,
  input logic             query_valid,
  input logic             result_valid,
  input logic             cfg_loaded,
  input logic [DEPTH-1:0] leaf_index
);

  // One cycle per level plus the encoder, in both directions
  a_result_follows_query: assert property (@(posedge clk) disable iff (!rst_n)
    $past(query_valid, DEPTH + 1) |-> result_valid)
    else $error("result_valid missing DEPTH+1 cycles after a query");

  a_no_result_without_query: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(query_valid, DEPTH + 1))
    else $error("result_valid without a query DEPTH+1 cycles earlier");

  // Outputs cleared by a reset cycle
  a_reset_clears: assert property (@(posedge clk)
    $past(!rst_n) |-> (!result_valid && !cfg_loaded))
    else $error("result_valid or cfg_loaded high during reset");

  a_leaf_known: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> !$isunknown(leaf_index))
    else $error("leaf_index has unknown bits with result_valid high");

endmodule

bind kd_tree_top kd_tree_props #(.DEPTH(DEPTH)) u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .query_valid  (query_valid),
  .result_valid (result_valid),
  .cfg_loaded   (cfg_loaded),
  .leaf_index   (leaf_index)
);

/* tb/kd_tree_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// KD-tree search testbench
// Directed tests against a node array model with an in-order scoreboard
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kd_tree_tb
  import kd_pkg::*;
();

  localparam int DEPTH         = 6;
  localparam int NUM_NODES     = (2**DEPTH) - 1;
  localparam int CLK_PERIOD    = 8;
  localparam int NUM_DIRECTED  = 8;
  localparam int NUM_RANDOM    = 200;
  localparam int NUM_GAPPED    = 40;
  localparam int NUM_RELOAD    = 20;
  localparam int TOTAL_QUERIES = 1 + NUM_DIRECTED + NUM_RANDOM + NUM_GAPPED + NUM_RELOAD;
  localparam int TOTAL_WRITES  = 2 * NUM_NODES + 3;
  // Worst case per query is pipeline drain plus an idle gap
  localparam int WATCHDOG_CYCLES = 16 * TOTAL_QUERIES + 4 * TOTAL_WRITES + 100;

  logic             clk;
  logic             rst_n;
  logic             cfg_start;
  logic             cfg_wen;
  node_word_t       cfg_data;
  logic             query_valid;
  patch_t           query_patch;
  logic             result_valid;
  logic [DEPTH-1:0] leaf_index;
  logic             leaf_miss;
  logic             cfg_loaded;

  // Reference node array in breadth-first order
  dim_t   model_dim [NUM_NODES];
  coord_t model_med [NUM_NODES];

  logic [DEPTH-1:0] exp_leaf_q [$];  // Scoreboard with one entry per query in flight
  logic             exp_miss_q [$];
  int               query_count  = 0;
  int               result_count = 0;
  logic             have_result  = 1'b0;  // Output hold checks start after first result
  logic [DEPTH-1:0] last_leaf;
  logic             last_miss;
  logic [31:0]      lcg_state = 32'd93325;

  kd_tree_top #(.DEPTH(DEPTH)) dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_start    (cfg_start),
    .cfg_wen      (cfg_wen),
    .cfg_data     (cfg_data),
    .query_valid  (query_valid),
    .query_patch  (query_patch),
    .result_valid (result_valid),
    .leaf_index   (leaf_index),
    .leaf_miss    (leaf_miss),
    .cfg_loaded   (cfg_loaded)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_error(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_leaf(input string name, input logic [DEPTH-1:0] got,
                            input logic [DEPTH-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic coord_t rand_coord();
    logic [31:0] r;
    r = lcg_next();
    return coord_t'(r[26:16]);  // Upper bits since the low LCG bits cycle fast
  endfunction

  function automatic dim_t rand_dim();
    logic [31:0] r;
    r = lcg_next();
    return dim_t'((r >> 16) % 32'd5);
  endfunction

  function automatic patch_t rand_patch();
    patch_t p;
    for (int d = 0; d < NUM_DIMS; d++) p[d*COORD_W +: COORD_W] = rand_coord();
    return p;
  endfunction

  // Walk the model tree with signed compares and ties going right
  // A bad dimension compares 0 and flags a miss
  task automatic model_search(input patch_t p, output logic [DEPTH-1:0] leaf, output logic miss);
    int               n;
    dim_t             d;
    coord_t           c;
    logic [DEPTH-1:0] path;
    path = '0;
    miss = 1'b0;
    for (int l = 0; l < DEPTH; l++) begin
      n = (2**l) - 1 + int'(path);  // Slot within level equals path so far
      d = model_dim[n];
      if (d < dim_t'(NUM_DIMS)) begin
        c = p[int'(d)*COORD_W +: COORD_W];
      end else begin
        c    = '0;
        miss = 1'b1;
      end
      path = {path[DEPTH-2:0], !(c < model_med[n])};
    end
    leaf = path;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      cfg_start   <= 1'b0;
      cfg_wen     <= 1'b0;
      query_valid <= 1'b0;
    end
  endtask

  task automatic write_node(input int n, input dim_t d, input coord_t m);
    @(posedge clk);
    cfg_wen  <= 1'b1;
    cfg_data <= {m, 8'h00, d};  // Median high, dimension low
    model_dim[n] = d;
    model_med[n] = m;
  endtask

  task automatic send_query_expect(input patch_t p, input logic [DEPTH-1:0] leaf,
                                   input logic miss);
    @(posedge clk);
    cfg_wen     <= 1'b0;
    query_valid <= 1'b1;
    query_patch <= p;
    exp_leaf_q.push_back(leaf);
    exp_miss_q.push_back(miss);
    query_count++;
  endtask

  task automatic send_query(input patch_t p);
    logic [DEPTH-1:0] leaf;
    logic             miss;
    model_search(p, leaf, miss);
    send_query_expect(p, leaf, miss);
  endtask

  // Idle until the scoreboard empties and watch a few more cycles for stray results
  task automatic wait_drain();
    idle_cycles(1);
    while (exp_leaf_q.size() != 0) @(posedge clk);
    repeat (DEPTH + 2) @(posedge clk);
    if (result_count != query_count) begin
      report_error($sformatf("Got %0d results for %0d queries", result_count, query_count));
    end
  endtask

  // Result monitor reads values settled since the previous edge
  always @(posedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_leaf_q.size() == 0) begin
        report_error("result_valid went high with no query outstanding");
      end else begin
        check_leaf("leaf_index", leaf_index, exp_leaf_q.pop_front());
        check_bit("leaf_miss", leaf_miss, exp_miss_q.pop_front());
        result_count++;
        have_result <= 1'b1;
        last_leaf   <= leaf_index;
        last_miss   <= leaf_miss;
      end
    end else if (rst_n && have_result) begin
      check_leaf("leaf_index held", leaf_index, last_leaf);  // Must not move between results
      check_bit("leaf_miss held", leaf_miss, last_miss);
    end
  end

  task automatic test_reset_state();
    check_bit("result_valid", result_valid, 1'b0);
    check_bit("cfg_loaded", cfg_loaded, 1'b0);
    send_query_expect(rand_patch(), 6'h3f, 1'b1);  // 0 vs median 0 goes right everywhere
    wait_drain();
  endtask

  task automatic test_directed_tree();
    for (int n = 0; n < NUM_NODES; n++) begin
      check_bit("cfg_loaded", cfg_loaded, 1'b0);  // Still low before last write lands
      write_node(n, dim_t'(n % NUM_DIMS), coord_t'((n % 7) * 64 - 192));
    end
    idle_cycles(1);                             // Edge that takes the last write
    check_bit("cfg_loaded", cfg_loaded, 1'b0);  // Value from before that write
    idle_cycles(1);
    check_bit("cfg_loaded", cfg_loaded, 1'b1);  // Rose with the last write
    send_query(patch_t'(0));
    send_query({NUM_DIMS{11'h7ff}});                  // All -1
    send_query_expect({NUM_DIMS{11'h400}}, 6'h00, 1'b0);  // Below every median
    send_query_expect({NUM_DIMS{11'h3ff}}, 6'h3f, 1'b0);  // Above every median
    send_query({11'sd0, 11'sd0, 11'sd0, 11'sd0, -11'sd192});  // Tie at the root
    send_query({11'sd64, 11'sd0, -11'sd64, -11'sd128, -11'sd192});
    send_query({-11'sd1, 11'sd1000, -11'sd7, 11'sd300, -11'sd500});
    send_query(rand_patch());
    wait_drain();
  endtask

  task automatic test_random_stream();
    for (int n = 0; n < NUM_NODES; n++) write_node(n, rand_dim(), rand_coord());
    idle_cycles(2);
    check_bit("cfg_loaded", cfg_loaded, 1'b1);
    for (int q = 0; q < NUM_RANDOM; q++) send_query(rand_patch());  // Back to back
    wait_drain();
  endtask

  task automatic test_idle_gaps();
    logic [31:0] r;
    for (int q = 0; q < NUM_GAPPED; q++) begin
      send_query(rand_patch());
      r = lcg_next();
      idle_cycles(int'(r[17:16]));  // 0 to 3 idle cycles
    end
    wait_drain();
  endtask

  task automatic test_partial_reload();
    check_bit("cfg_loaded", cfg_loaded, 1'b1);
    @(posedge clk);
    cfg_start <= 1'b1;
    idle_cycles(2);
    check_bit("cfg_loaded", cfg_loaded, 1'b0);
    // New root and level 1 while deeper nodes keep old contents
    for (int n = 0; n < 3; n++) begin
      write_node(n, dim_t'((int'(model_dim[n]) + 2) % NUM_DIMS), rand_coord());
    end
    idle_cycles(2);
    check_bit("cfg_loaded", cfg_loaded, 1'b0);
    for (int q = 0; q < NUM_RELOAD; q++) send_query(rand_patch());
    wait_drain();
  endtask

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_error("Watchdog expired, the run did not finish in time");
  end

  initial begin
    rst_n       = 1'b0;
    cfg_start   = 1'b0;
    cfg_wen     = 1'b0;
    cfg_data    = '0;
    query_valid = 1'b0;
    query_patch = '0;
    for (int n = 0; n < NUM_NODES; n++) begin
      model_dim[n] = DIM_UNSET;  // Matches node reset state
      model_med[n] = '0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset_state();
    test_directed_tree();
    test_random_stream();
    test_idle_gaps();
    test_partial_reload();
    if (result_count == TOTAL_QUERIES && exp_leaf_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_error($sformatf("Run ended with %0d of %0d results", result_count, TOTAL_QUERIES));
    end
  end

endmodule

/* verilog.f */
design/kd_pkg.sv
design/kd_node_loader.sv
design/kd_tree_level.sv
design/kd_leaf_encoder.sv
design/kd_tree_top.sv
tb/kd_tree_props.sv
tb/kd_tree_tb.sv
